/* logic/agu_settings.svh */
`ifndef AGU_SETTINGS_SVH
`define AGU_SETTINGS_SVH

// data path and address width
`define AGU_DATA_W 32

// reorder buffer entry number
`define AGU_TAG_W 4

// physical destination register
`define AGU_PREG_W 6

// offset field of a memory instruction
`define AGU_IMM_W 16

// address error codes, load then store
`define AGU_EXCCODE_ADEL 4
`define AGU_EXCCODE_ADES 5

`endif

/* logic/mem_op_pkg.sv */
`include "agu_settings.svh"

package mem_op_pkg;

    // memory operations seen by the unit
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_t;

    // bus transfer size, encoded as log2 of the byte count
    typedef logic [2:0] mem_size_t;
    typedef logic [3:0] byte_strobe_t;
    typedef logic [`AGU_DATA_W-1:0] word_t;

    localparam mem_size_t SIZE_BYTE = 3'd0;
    localparam mem_size_t SIZE_HALF = 3'd1;
    localparam mem_size_t SIZE_WORD = 3'd2;

endpackage

/* logic/agu_pkg.sv */
`include "agu_settings.svh"

package agu_pkg;

    typedef logic [`AGU_TAG_W-1:0]  rob_tag_t;
    typedef logic [`AGU_PREG_W-1:0] preg_t;

    // occupancy of the address queue
    // head only, then head plus one or two buffered entries
    typedef enum logic [1:0] {
        Q_EMPTY,
        Q_ONE,
        Q_TWO_FULL1,
        Q_TWO_FULL2
    } queue_state_t;

endpackage

/* logic/agu_addr_queue.sv */
`include "agu_settings.svh"

module agu_addr_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  issue_valid,
    input  mem_op_pkg::mem_op_t   issue_op,
    input  mem_op_pkg::word_t     issue_base,
    input  logic [`AGU_IMM_W-1:0] issue_imm,
    input  mem_op_pkg::word_t     issue_store_value,
    input  agu_pkg::preg_t        issue_dest,
    input  agu_pkg::rob_tag_t     issue_tag,
    output logic                  allowin,
    input  logic                  store_allowin,
    input  logic                  load_allowin,
    output logic                  head_valid,
    output logic                  head_is_store,
    output mem_op_pkg::mem_op_t   head_op,
    output mem_op_pkg::word_t     head_addr,
    output mem_op_pkg::word_t     head_store_value,
    output agu_pkg::preg_t        head_dest,
    output agu_pkg::rob_tag_t     head_tag
);

    agu_pkg::queue_state_t state, state_next;
    logic push, pop, head_we, buf_we, use_buf;
    logic buf_head, buf_tail;
    mem_op_pkg::word_t entry_addr;

    mem_op_pkg::mem_op_t buf_op    [2];
    mem_op_pkg::word_t   buf_addr  [2];
    mem_op_pkg::word_t   buf_value [2];
    agu_pkg::preg_t      buf_dest  [2];
    agu_pkg::rob_tag_t   buf_tag   [2];

    // effective address, computed once on entry
    assign entry_addr = issue_base
                      + {{(`AGU_DATA_W-`AGU_IMM_W){issue_imm[`AGU_IMM_W-1]}}, issue_imm};

    assign head_valid    = state != agu_pkg::Q_EMPTY;
    assign allowin       = state != agu_pkg::Q_TWO_FULL2;
    assign head_is_store = head_op inside {mem_op_pkg::OP_SB, mem_op_pkg::OP_SH,
                                           mem_op_pkg::OP_SW};

    assign push = issue_valid && allowin;
    assign pop  = head_valid && (head_is_store ? store_allowin : load_allowin);

    // head is refilled from the issue port or from the oldest buffered entry
    assign use_buf = pop && (state == agu_pkg::Q_TWO_FULL1 || state == agu_pkg::Q_TWO_FULL2);
    assign head_we = (state == agu_pkg::Q_EMPTY && push)
                  || (state == agu_pkg::Q_ONE && push && pop)
                  || use_buf;
    assign buf_we  = (state == agu_pkg::Q_ONE && push && !pop)
                  || (state == agu_pkg::Q_TWO_FULL1 && push);

    always_comb begin
        unique case (state)
            agu_pkg::Q_EMPTY:     state_next = push ? agu_pkg::Q_ONE : agu_pkg::Q_EMPTY;
            agu_pkg::Q_ONE:       state_next = push ? (pop ? agu_pkg::Q_ONE : agu_pkg::Q_TWO_FULL1)
                                                    : (pop ? agu_pkg::Q_EMPTY : agu_pkg::Q_ONE);
            agu_pkg::Q_TWO_FULL1: state_next = push ? (pop ? agu_pkg::Q_TWO_FULL1
                                                           : agu_pkg::Q_TWO_FULL2)
                                                    : (pop ? agu_pkg::Q_ONE
                                                           : agu_pkg::Q_TWO_FULL1);
            default:              state_next = pop ? agu_pkg::Q_TWO_FULL1 : agu_pkg::Q_TWO_FULL2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state    <= agu_pkg::Q_EMPTY;
            buf_head <= 1'b0;
            buf_tail <= 1'b0;
        end else begin
            state <= state_next;
            if (use_buf)
                buf_head <= !buf_head;
            if (buf_we)
                buf_tail <= !buf_tail;
        end
    end

    always_ff @(posedge clk) begin
        if (head_we) begin
            head_op          <= use_buf ? buf_op[buf_head]    : issue_op;
            head_addr        <= use_buf ? buf_addr[buf_head]  : entry_addr;
            head_store_value <= use_buf ? buf_value[buf_head] : issue_store_value;
            head_dest        <= use_buf ? buf_dest[buf_head]  : issue_dest;
            head_tag         <= use_buf ? buf_tag[buf_head]   : issue_tag;
        end
        if (buf_we) begin
            buf_op[buf_tail]    <= issue_op;
            buf_addr[buf_tail]  <= entry_addr;
            buf_value[buf_tail] <= issue_store_value;
            buf_dest[buf_tail]  <= issue_dest;
            buf_tag[buf_tail]   <= issue_tag;
        end
    end

endmodule

/* logic/agu_store_stage.sv */
module agu_store_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     head_valid,
    input  logic                     head_is_store,
    input  mem_op_pkg::mem_op_t      head_op,
    input  mem_op_pkg::word_t        head_addr,
    input  mem_op_pkg::word_t        head_store_value,
    input  agu_pkg::rob_tag_t        head_tag,
    output logic                     store_allowin,
    input  logic                     store_ready,
    output logic                     store_valid,
    output agu_pkg::rob_tag_t        store_tag,
    output mem_op_pkg::word_t        store_addr,
    output mem_op_pkg::word_t        store_data,
    output mem_op_pkg::byte_strobe_t store_strobe,
    output mem_op_pkg::mem_size_t    store_size,
    output logic                     store_addr_error
);

    mem_op_pkg::mem_op_t st_op;
    mem_op_pkg::word_t   st_value;

    assign store_allowin = !store_valid || store_ready;

    always_ff @(posedge clk) begin
        if (reset || flush)
            store_valid <= 1'b0;
        else if (store_allowin)
            store_valid <= head_valid && head_is_store;
    end

    // payload only moves with a store
    always_ff @(posedge clk) begin
        if (store_allowin && head_valid && head_is_store) begin
            st_op      <= head_op;
            st_value   <= head_store_value;
            store_addr <= head_addr;
            store_tag  <= head_tag;
        end
    end

    // lane strobe, size and replicated data from op and low address bits
    always_comb begin
        unique case (st_op)
            mem_op_pkg::OP_SB: begin
                store_strobe = 4'b0001 << store_addr[1:0];
                store_size   = mem_op_pkg::SIZE_BYTE;
                store_data   = {4{st_value[7:0]}};
            end
            mem_op_pkg::OP_SH: begin
                store_strobe = store_addr[1] ? 4'b1100 : 4'b0011;
                store_size   = mem_op_pkg::SIZE_HALF;
                store_data   = {2{st_value[15:0]}};
            end
            default: begin
                store_strobe = (st_op == mem_op_pkg::OP_SW) ? 4'b1111 : 4'b0000;
                store_size   = mem_op_pkg::SIZE_WORD;
                store_data   = st_value;
            end
        endcase
    end

    assign store_addr_error = (st_op == mem_op_pkg::OP_SH && store_addr[0])
                           || (st_op == mem_op_pkg::OP_SW && store_addr[1:0] != 2'b00);

endmodule

/* logic/agu_load_pipe.sv */
module agu_load_pipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  head_valid,
    input  logic                  head_is_store,
    input  mem_op_pkg::mem_op_t   head_op,
    input  mem_op_pkg::word_t     head_addr,
    input  agu_pkg::preg_t        head_dest,
    input  agu_pkg::rob_tag_t     head_tag,
    output logic                  load_allowin,
    output logic                  dcache_req,
    output mem_op_pkg::word_t     dcache_addr,
    output mem_op_pkg::mem_size_t dcache_size,
    input  logic                  dcache_addr_ok,
    input  logic                  dcache_data_ok,
    input  mem_op_pkg::word_t     dcache_rdata,
    input  logic                  load_ready,
    output logic                  load_valid,
    output agu_pkg::rob_tag_t     load_tag,
    output agu_pkg::preg_t        load_dest,
    output mem_op_pkg::word_t     load_result,
    output logic                  load_addr_error
);

    logic req_valid, req_misaligned, req_readygo, req_allowin;
    logic resp_valid, resp_misaligned, resp_parked, resp_readygo, resp_allowin, resp_to_valid;
    logic done_allowin, data_hit, data_cancel, owed;
    mem_op_pkg::mem_op_t req_op, resp_op;
    agu_pkg::preg_t      req_dest, resp_dest;
    agu_pkg::rob_tag_t   req_tag, resp_tag;
    logic [1:0]          resp_offset;
    mem_op_pkg::word_t   ext_result, park_result;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;

    // request stage
    assign req_misaligned = (req_op inside {mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU} && dcache_addr[0])
                         || (req_op == mem_op_pkg::OP_LW && dcache_addr[1:0] != 2'b00);
    // only one uncancelled request outstanding, so data always finds the response stage
    assign dcache_req   = req_valid && !req_misaligned && !resp_valid;
    assign req_readygo  = req_misaligned || (dcache_req && dcache_addr_ok);
    assign req_allowin  = !req_valid || (req_readygo && resp_allowin);
    assign load_allowin = req_allowin;

    always_comb begin
        unique case (req_op)
            mem_op_pkg::OP_LB, mem_op_pkg::OP_LBU: dcache_size = mem_op_pkg::SIZE_BYTE;
            mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU: dcache_size = mem_op_pkg::SIZE_HALF;
            default:                               dcache_size = mem_op_pkg::SIZE_WORD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            req_valid <= 1'b0;
        else if (req_allowin)
            req_valid <= head_valid && !head_is_store;
        if (req_allowin && head_valid && !head_is_store) begin
            req_op      <= head_op;
            dcache_addr <= head_addr;
            req_dest    <= head_dest;
            req_tag     <= head_tag;
        end
    end

    // response stage
    assign data_hit      = dcache_data_ok && !data_cancel;
    assign resp_readygo  = data_hit || resp_misaligned || resp_parked;
    assign resp_allowin  = !resp_valid || (resp_readygo && done_allowin);
    assign resp_to_valid = resp_valid && resp_readygo;

    assign byte_sel = dcache_rdata[8*resp_offset +: 8];
    assign half_sel = dcache_rdata[16*resp_offset[1] +: 16];

    always_comb begin
        unique case (resp_op)
            mem_op_pkg::OP_LB:  ext_result = {{24{byte_sel[7]}}, byte_sel};
            mem_op_pkg::OP_LBU: ext_result = {24'b0, byte_sel};
            mem_op_pkg::OP_LH:  ext_result = {{16{half_sel[15]}}, half_sel};
            mem_op_pkg::OP_LHU: ext_result = {16'b0, half_sel};
            default:            ext_result = dcache_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            resp_valid <= 1'b0;
        else if (resp_allowin)
            resp_valid <= req_valid && req_readygo;
        if (resp_allowin && req_valid && req_readygo) begin
            resp_op         <= req_op;
            resp_offset     <= dcache_addr[1:0];
            resp_dest       <= req_dest;
            resp_tag        <= req_tag;
            resp_misaligned <= req_misaligned;
        end
    end

    // hold returned data while the done stage is blocked
    always_ff @(posedge clk) begin
        if (reset || flush || resp_allowin)
            resp_parked <= 1'b0;
        else if (resp_valid && !resp_parked && data_hit)
            resp_parked <= 1'b1;
        if (!resp_allowin && resp_valid && !resp_parked && data_hit)
            park_result <= ext_result;
    end

    // flush leaves a data-ok owed to an accepted request
    assign owed = (resp_valid && !resp_misaligned && !resp_parked && !data_hit)
               || (dcache_req && dcache_addr_ok);

    always_ff @(posedge clk) begin
        if (reset)
            data_cancel <= 1'b0;
        else if (flush && owed)
            data_cancel <= 1'b1;
        else if (dcache_data_ok)
            data_cancel <= 1'b0;
    end

    // done stage
    assign done_allowin = !load_valid || load_ready;

    always_ff @(posedge clk) begin
        if (reset || flush)
            load_valid <= 1'b0;
        else if (done_allowin)
            load_valid <= resp_to_valid;
        if (done_allowin && resp_to_valid) begin
            load_tag        <= resp_tag;
            load_dest       <= resp_dest;
            load_addr_error <= resp_misaligned;
            if (resp_misaligned)
                load_result <= '0;
            else
                load_result <= resp_parked ? park_result : ext_result;
        end
    end

endmodule

/* logic/agu_top.sv */
`include "agu_settings.svh"

module agu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     issue_valid,
    input  mem_op_pkg::mem_op_t      issue_op,
    input  mem_op_pkg::word_t        issue_base,
    input  logic [`AGU_IMM_W-1:0]    issue_imm,
    input  mem_op_pkg::word_t        issue_store_value,
    input  agu_pkg::preg_t           issue_dest,
    input  agu_pkg::rob_tag_t        issue_tag,
    output logic                     allowin,
    input  logic                     store_ready,
    output logic                     store_valid,
    output agu_pkg::rob_tag_t        store_tag,
    output mem_op_pkg::word_t        store_addr,
    output mem_op_pkg::word_t        store_data,
    output mem_op_pkg::byte_strobe_t store_strobe,
    output mem_op_pkg::mem_size_t    store_size,
    output logic                     store_addr_error,
    output logic                     dcache_req,
    output mem_op_pkg::word_t        dcache_addr,
    output mem_op_pkg::mem_size_t    dcache_size,
    input  logic                     dcache_addr_ok,
    input  logic                     dcache_data_ok,
    input  mem_op_pkg::word_t        dcache_rdata,
    input  logic                     load_ready,
    output logic                     load_valid,
    output agu_pkg::rob_tag_t        load_tag,
    output agu_pkg::preg_t           load_dest,
    output mem_op_pkg::word_t        load_result,
    output logic                     load_addr_error
);

    // queue head, shared by both paths
    logic                head_valid;
    logic                head_is_store;
    mem_op_pkg::mem_op_t head_op;
    mem_op_pkg::word_t   head_addr;
    mem_op_pkg::word_t   head_store_value;
    agu_pkg::preg_t      head_dest;
    agu_pkg::rob_tag_t   head_tag;
    logic                store_allowin;
    logic                load_allowin;

    agu_addr_queue u_addr_queue (.*);

    // stores are formatted for the commit side
    agu_store_stage u_store_stage (.*);

    // loads go to the dcache
    agu_load_pipe u_load_pipe (.*);

endmodule

/* verification/agu_clock_gen.sv */
module agu_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over the first five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
    end
endmodule

/* verification/agu_asserts.sv */
module agu_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush,
    input logic                     allowin,
    input logic                     store_valid,
    input logic                     store_ready,
    input agu_pkg::rob_tag_t        store_tag,
    input mem_op_pkg::word_t        store_addr,
    input mem_op_pkg::word_t        store_data,
    input mem_op_pkg::byte_strobe_t store_strobe,
    input mem_op_pkg::mem_size_t    store_size,
    input logic                     store_addr_error,
    input logic                     load_valid,
    input logic                     load_ready,
    input agu_pkg::rob_tag_t        load_tag,
    input agu_pkg::preg_t           load_dest,
    input mem_op_pkg::word_t        load_result,
    input logic                     load_addr_error,
    input logic                     dcache_req,
    input mem_op_pkg::word_t        dcache_addr,
    input mem_op_pkg::mem_size_t    dcache_size,
    input logic                     dcache_addr_ok
);
    timeunit 1ns;
    timeprecision 100ps;

    // held store output keeps its payload
    store_hold: assert property (@(posedge clk) disable iff (reset)
        store_valid && !store_ready && !flush |=> store_valid
            && $stable({store_tag, store_addr, store_data, store_strobe, store_size,
                        store_addr_error}))
        else $error("store output changed while held");

    load_hold: assert property (@(posedge clk) disable iff (reset)
        load_valid && !load_ready && !flush |=> load_valid
            && $stable({load_tag, load_dest, load_result, load_addr_error}))
        else $error("load output changed while held");

    // request stays up until the cache takes it
    req_hold: assert property (@(posedge clk) disable iff (reset)
        dcache_req && !dcache_addr_ok && !flush |=> dcache_req
            && $stable({dcache_addr, dcache_size}))
        else $error("dcache request dropped before addr_ok");

    reset_clear: assert property (@(posedge clk)
        reset |=> !store_valid && !load_valid && !dcache_req && allowin)
        else $error("valid high in the cycle after reset");
endmodule

bind agu_top agu_asserts u_asserts (.*);

/* verification/agu_tb.sv */
`include "agu_settings.svh"

module agu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_MIXED     = 120;
    localparam int N_PRESSURE  = 150;
    localparam int N_FLUSH     = 144;
    localparam int CYCLE_LIMIT = 40 * (N_MIXED + N_PRESSURE + N_FLUSH) + 200;
    // cache data is the word address scrambled by this key
    localparam logic [31:0] XOR_KEY = 32'h5a3c_96e1;

    typedef struct packed {
        agu_pkg::rob_tag_t        tag;
        mem_op_pkg::word_t        addr;
        mem_op_pkg::word_t        data;
        mem_op_pkg::byte_strobe_t strobe;
        mem_op_pkg::mem_size_t    size;
        logic                     err;
    } store_exp_t;

    typedef struct packed {
        agu_pkg::rob_tag_t tag;
        agu_pkg::preg_t    dest;
        mem_op_pkg::word_t result;
        logic              err;
    } load_exp_t;

    logic clk, reset, flush, issue_valid, allowin;
    mem_op_pkg::mem_op_t issue_op;
    mem_op_pkg::word_t issue_base, issue_store_value, store_addr, store_data;
    logic [`AGU_IMM_W-1:0] issue_imm;
    agu_pkg::preg_t issue_dest, load_dest;
    agu_pkg::rob_tag_t issue_tag, store_tag, load_tag;
    logic store_ready, store_valid, store_addr_error;
    mem_op_pkg::byte_strobe_t store_strobe;
    mem_op_pkg::mem_size_t store_size, dcache_size;
    logic dcache_req, dcache_addr_ok, dcache_data_ok;
    mem_op_pkg::word_t dcache_addr, dcache_rdata, load_result;
    logic load_ready, load_valid, load_addr_error;

    store_exp_t store_q[$];
    load_exp_t load_q[$];
    // dcache requests expected from aligned loads, in order
    mem_op_pkg::word_t req_addr_q[$];
    mem_op_pkg::mem_size_t req_size_q[$];
    mem_op_pkg::word_t ret_data[$];
    int ret_due[$];
    int cyc, errors, checks, outputs, accepted, issue_left, ready_pct;
    int adel_seen, ades_seen;
    bit arm_flush;
    logic [3:0] next_tag;

    agu_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    agu_top u_dut (.*);

    function automatic bit chance(int pct);
        return $urandom_range(0, 99) < pct;
    endfunction

    function automatic mem_op_pkg::word_t model_word(mem_op_pkg::word_t addr);
        return {addr[31:2], 2'b00} ^ XOR_KEY;
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // random instruction, mostly aligned, pushed to the model once accepted
    task automatic make_issue();
        mem_op_pkg::mem_op_t op;
        mem_op_pkg::word_t ea, w, v;
        logic [15:0] imm;
        logic [7:0] b;
        logic [15:0] h;
        logic odd;
        store_exp_t s;
        load_exp_t l;
        op = mem_op_pkg::mem_op_t'(4'($urandom_range(1, 8)));
        imm = 16'($urandom);
        ea = $urandom;
        v = $urandom;
        odd = chance(12);
        if (op inside {mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU, mem_op_pkg::OP_SH})
            ea[0] = odd;
        else if (op inside {mem_op_pkg::OP_LW, mem_op_pkg::OP_SW})
            ea[1:0] = odd ? 2'($urandom_range(1, 3)) : 2'b00;
        issue_valid = 1'b1;
        issue_op = op;
        issue_imm = imm;
        issue_base = ea - {{16{imm[15]}}, imm};
        issue_store_value = v;
        issue_dest = 6'($urandom);
        issue_tag = next_tag;
        if (allowin) begin
            accepted++;
            issue_left--;
            next_tag = next_tag + 4'd1;
            if (op inside {mem_op_pkg::OP_SB, mem_op_pkg::OP_SH, mem_op_pkg::OP_SW}) begin
                s.tag = issue_tag;
                s.addr = ea;
                s.strobe = (op == mem_op_pkg::OP_SB) ? 4'b0001 << ea[1:0]
                         : (op == mem_op_pkg::OP_SH) ? (ea[1] ? 4'b1100 : 4'b0011) : 4'b1111;
                s.size = (op == mem_op_pkg::OP_SB) ? 3'd0 : (op == mem_op_pkg::OP_SH) ? 3'd1 : 3'd2;
                s.data = (op == mem_op_pkg::OP_SB) ? {4{v[7:0]}}
                       : (op == mem_op_pkg::OP_SH) ? {2{v[15:0]}} : v;
                s.err = (op == mem_op_pkg::OP_SH && ea[0]) || (op == mem_op_pkg::OP_SW && odd);
                store_q.push_back(s);
            end else begin
                w = model_word(ea);
                b = 8'(w >> {ea[1:0], 3'b000});
                h = ea[1] ? w[31:16] : w[15:0];
                l.tag = issue_tag;
                l.dest = issue_dest;
                l.err = (op inside {mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU, mem_op_pkg::OP_LW}) && odd;
                case (op)
                    mem_op_pkg::OP_LB:  l.result = {{24{b[7]}}, b};
                    mem_op_pkg::OP_LBU: l.result = {24'b0, b};
                    mem_op_pkg::OP_LH:  l.result = {{16{h[15]}}, h};
                    mem_op_pkg::OP_LHU: l.result = {16'b0, h};
                    default:            l.result = w;
                endcase
                load_q.push_back(l);
                // misaligned loads never reach the bus
                if (!l.err) begin
                    req_addr_q.push_back(ea);
                    req_size_q.push_back((op inside {mem_op_pkg::OP_LB, mem_op_pkg::OP_LBU}) ? 3'd0
                                       : (op inside {mem_op_pkg::OP_LH, mem_op_pkg::OP_LHU}) ? 3'd1
                                       : 3'd2);
                end
            end
        end
    endtask

    task automatic take_store();
        store_exp_t s;
        outputs++;
        if (store_q.size() == 0) begin
            $display("unexpected store output at %0t with tag %h", $time, store_tag);
            errors++;
        end else begin
            s = store_q.pop_front();
            check_value("store_tag", 32'(store_tag), 32'(s.tag));
            check_value("store_addr", store_addr, s.addr);
            check_value("store_strobe", 32'(store_strobe), 32'(s.strobe));
            check_value("store_size", 32'(store_size), 32'(s.size));
            check_value("store_data", store_data, s.data);
            check_value("store_addr_error", 32'(store_addr_error), 32'(s.err));
            if (store_addr_error)
                ades_seen++;
        end
    endtask

    task automatic take_load();
        load_exp_t l;
        outputs++;
        if (load_q.size() == 0) begin
            $display("unexpected load output at %0t with tag %h", $time, load_tag);
            errors++;
        end else begin
            l = load_q.pop_front();
            check_value("load_tag", 32'(load_tag), 32'(l.tag));
            check_value("load_dest", 32'(load_dest), 32'(l.dest));
            check_value("load_addr_error", 32'(load_addr_error), 32'(l.err));
            // result of an address-error load is not defined
            if (!l.err)
                check_value("load_result", load_result, l.result);
            if (load_addr_error)
                adel_seen++;
        end
    endtask

    // in-order cache, one data pulse per accepted request
    task automatic drive_dcache();
        int due;
        dcache_data_ok = 1'b0;
        if (ret_due.size() > 0 && ret_due[0] <= cyc) begin
            dcache_data_ok = 1'b1;
            dcache_rdata = ret_data.pop_front();
            void'(ret_due.pop_front());
        end
        dcache_addr_ok = chance(60);
        if (dcache_req && dcache_addr_ok) begin
            // a request taken in the flush cycle belongs to a flushed load
            if (!flush) begin
                if (req_addr_q.size() == 0) begin
                    $display("dcache request at %0t for address %h with no load waiting",
                             $time, dcache_addr);
                    errors++;
                end else begin
                    check_value("dcache_addr", dcache_addr, req_addr_q.pop_front());
                    check_value("dcache_size", 32'(dcache_size), 32'(req_size_q.pop_front()));
                end
            end
            due = cyc + 1 + int'($urandom_range(0, 4));
            if (ret_due.size() > 0 && due <= ret_due[$])
                due = ret_due[$] + 1;
            ret_due.push_back(due);
            ret_data.push_back(model_word(dcache_addr));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
        cyc++;
        // flush only while exactly one request waits for its data
        flush = arm_flush && ret_due.size() == 1 && ret_due[0] > cyc;
        issue_valid = 1'b0;
        if (flush) begin
            accepted -= store_q.size() + load_q.size();
            store_q.delete();
            load_q.delete();
            req_addr_q.delete();
            req_size_q.delete();
            arm_flush = 1'b0;
            store_ready = 1'b0;
            load_ready = 1'b0;
        end else begin
            store_ready = chance(ready_pct);
            load_ready = chance(ready_pct);
            if (store_valid && store_ready)
                take_store();
            if (load_valid && load_ready)
                take_load();
            if (issue_left > 0 && chance(70))
                make_issue();
        end
        drive_dcache();
    endtask

    task automatic run_stream(string name, int n, int rpct, bit with_flush);
        int err0;
        err0 = errors;
        accepted = 0;
        outputs = 0;
        issue_left = n;
        ready_pct = rpct;
        while (issue_left > 0 || arm_flush) begin
            // one flush per stream
            if (with_flush && issue_left == n / 2) begin
                arm_flush = 1'b1;
                with_flush = 1'b0;
            end
            // keep loads coming until the flush finds a request in flight
            if (issue_left == 0)
                issue_left = 1;
            step();
        end
        while (store_q.size() > 0 || load_q.size() > 0 || ret_due.size() > 0)
            step();
        repeat (6) step();
        check_value("output count", 32'(outputs), 32'(accepted));
        $display("%s: %0d accepted, %0d outputs, %0d errors", name, accepted, outputs,
                 errors - err0);
    endtask

    // run limit on the cycle count
    initial begin
        wait (cyc > CYCLE_LIMIT);
        $display("timeout after %0d cycles, outputs still missing", cyc);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(54789));
        flush = 1'b0;
        issue_valid = 1'b0;
        issue_op = mem_op_pkg::OP_NOP;
        issue_base = '0;
        issue_imm = '0;
        issue_store_value = '0;
        issue_dest = '0;
        issue_tag = '0;
        store_ready = 1'b0;
        load_ready = 1'b0;
        dcache_addr_ok = 1'b0;
        dcache_data_ok = 1'b0;
        dcache_rdata = '0;
        next_tag = 4'd0;
        arm_flush = 1'b0;
        @(negedge reset);
        run_stream("mixed stream", N_MIXED, 90, 1'b0);
        run_stream("ready back-pressure", N_PRESSURE, 40, 1'b0);
        for (int i = 0; i < 3; i++)
            run_stream("flush with request outstanding", N_FLUSH / 3, 70, 1'b1);
        if (adel_seen == 0 || ades_seen == 0) begin
            $display("no load or store address error was ever reported");
            errors++;
        end
        $display("%0d checks, %0d errors, exccode %0d seen %0d times, exccode %0d seen %0d times",
                 checks, errors, `AGU_EXCCODE_ADEL, adel_seen, `AGU_EXCCODE_ADES, ades_seen);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule

/* tb.f */
+incdir+logic
logic/mem_op_pkg.sv
logic/agu_pkg.sv
logic/agu_addr_queue.sv
logic/agu_store_stage.sv
logic/agu_load_pipe.sv
logic/agu_top.sv
verification/agu_clock_gen.sv
verification/agu_asserts.sv
verification/agu_tb.sv

/* Makefile */
TOP := agu_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f logic/*.sv logic/*.svh verification/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
